// File: src/vmem_bus_pkg.sv
/*
 * Memory bus definitions for the vector memory unit
 * Address, word and line widths plus the derived select widths
 */

package vmem_bus_pkg;

  localparam int ADDR_WIDTH         = 32;   // Byte address
  localparam int WORD_WIDTH         = 32;   // Element container
  localparam int LINE_WIDTH_DEFAULT = 128;  // Memory line, 4 words
  localparam int BYTE_SEL_WIDTH     = $clog2(WORD_WIDTH / 8);  // Byte within word

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Address bits that pick a word inside a line (line must hold 2+ words)
  function automatic int wsel_width(int line_width);
    return $clog2(line_width / WORD_WIDTH);
  endfunction

  // Width of an element index, never below one bit
  function automatic int lane_idx_width(int num_lanes);
    return (num_lanes > 1) ? $clog2(num_lanes) : 1;
  endfunction

endpackage

// File: src/vmem_op_pkg.sv
/*
 * Vector memory op word layout
 * Field positions, pattern and size codes, field accessors
 */

package vmem_op_pkg;

  // Op word from high to low is pattern(2) size(2) signed(1) store(1)
  localparam int OP_WIDTH      = 6;
  localparam int OP_PAT_LSB    = 4;
  localparam int OP_SIZE_LSB   = 2;
  localparam int OP_SIGNED_BIT = 1;
  localparam int OP_STORE_BIT  = 0;

  typedef logic [OP_WIDTH-1:0] op_t;

  localparam logic [1:0] PAT_UNIT   = 2'd0;  // base + elem*bytes
  localparam logic [1:0] PAT_STRIDE = 2'd1;  // base + elem*stride*bytes
  localparam logic [1:0] PAT_INDEX  = 2'd2;  // base + vindex[elem]

  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  function automatic logic [1:0] op_pattern(op_t op);
    return op[OP_PAT_LSB +: 2];
  endfunction

  function automatic logic [1:0] op_size(op_t op);
    return op[OP_SIZE_LSB +: 2];
  endfunction

  function automatic logic op_signed(op_t op);
    return op[OP_SIGNED_BIT];
  endfunction

  function automatic logic op_store(op_t op);
    return op[OP_STORE_BIT];
  endfunction

  // log2 of element bytes, so bytes = 1 << size_shift
  function automatic logic [1:0] size_shift(logic [1:0] size);
    case (size)
      SIZE_BYTE: return 2'd0;
      SIZE_HALF: return 2'd1;
      SIZE_WORD: return 2'd2;
      default:   return 2'd2;  // Unused code treated as word
    endcase
  endfunction

endpackage

// File: src/vmem_elem_if.sv
/*
 * Element bus between sequencer and address generator
 * Sequencer picks the element, generator returns its operands
 */

`timescale 1ns/100ps

interface vmem_elem_if #(
  parameter int NUM_LANES = 4
);

  // Driven by the sequencer
  logic                                                capture;  // Take new operands
  logic [vmem_bus_pkg::lane_idx_width(NUM_LANES)-1:0] elem;     // Current element
  logic                                                advance;  // Element finished
  vmem_op_pkg::op_t                                    op;       // Latched op word

  // Driven by the address generator
  logic                mask_bit;  // Mask of current element
  vmem_bus_pkg::addr_t addr;      // Byte address of current element
  vmem_bus_pkg::word_t wdata;     // Store data of current element

  modport ctrl (
    output capture, elem, advance, op,
    input  mask_bit, addr
  );

  modport gen (
    input  capture, elem, advance,
    output mask_bit, addr, wdata
  );

endinterface

// File: src/vmem_ctrl.sv
/*
 * Vector memory sequencer
 * Walks the elements in order, skips masked ones and runs the
 * one-request-per-element memory handshake
 */

`timescale 1ns/100ps

module vmem_ctrl #(
  parameter int NUM_LANES = 4
) (
  input  logic                                                clk,
  input  logic                                                resetn,
  input  logic                                                start,
  input  vmem_op_pkg::op_t                                    op,
  output logic                                                busy,
  output logic                                                done,
  vmem_elem_if.ctrl                                           elem,
  output logic                                                dmem_en,
  output logic                                                dmem_we,
  input  logic                                                dmem_wait,
  output logic                                                load_take,  // Read data valid
  output logic [vmem_bus_pkg::lane_idx_width(NUM_LANES)-1:0] load_elem
);

  localparam int LANE_W = vmem_bus_pkg::lane_idx_width(NUM_LANES);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_REQ    = 2'd1;  // Request or skip current element
  localparam logic [1:0] S_RDATA  = 2'd2;  // Load data returning
  localparam logic [1:0] S_FINISH = 2'd3;  // Done pulse

  logic [1:0]       state;
  logic [LANE_W-1:0] elem_q;
  vmem_op_pkg::op_t op_q;
  logic             last_elem;
  logic             is_store;
  logic             accepted;
  logic             elem_end;

  assign last_elem = (elem_q == LANE_W'(NUM_LANES - 1));
  assign is_store  = vmem_op_pkg::op_store(op_q);
  assign accepted  = dmem_en && !dmem_wait;

  // Element ends on a mask skip, an accepted store or the load data cycle
  assign elem_end = (state == S_REQ && (!elem.mask_bit || (accepted && is_store)))
                    || (state == S_RDATA);

  assign elem.capture = start && (state == S_IDLE);
  assign elem.elem    = elem_q;
  assign elem.advance = elem_end;
  assign elem.op      = op_q;

  assign busy      = (state != S_IDLE);
  assign done      = (state == S_FINISH);
  assign dmem_en   = (state == S_REQ) && elem.mask_bit;  // Held until accepted
  assign dmem_we   = dmem_en && is_store;
  assign load_take = (state == S_RDATA);
  assign load_elem = elem_q;  // Element stays put through the data cycle

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      state  <= S_IDLE;
      elem_q <= '0;
      op_q   <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (elem.capture)
          begin
            state  <= S_REQ;
            elem_q <= '0;
            op_q   <= op;
          end
        S_REQ, S_RDATA:
          if (elem_end)
          begin
            if (last_elem)
              state <= S_FINISH;
            else
            begin
              state  <= S_REQ;
              elem_q <= elem_q + 1'b1;
            end
          end
          else if (accepted)
            state <= S_RDATA;  // Load accepted, data next cycle
        default:
          state <= S_IDLE;  // FINISH, busy drops here
      endcase
    end
  end

  // Back-pressure must not disturb a pending request
  a_req_hold: assert property (@(posedge clk) disable iff (!resetn)
    dmem_en && dmem_wait |=> dmem_en && $stable(elem.addr) && $stable(dmem_we));

  a_done_idle_bus: assert property (@(posedge clk) disable iff (!resetn)
    !(done && dmem_en));

endmodule

// File: src/vmem_addr_gen.sv
/*
 * Element address generator
 * Holds the instruction's vector operands and forms the address,
 * mask bit and store word of the selected element
 */

`timescale 1ns/100ps

module vmem_addr_gen #(
  parameter int NUM_LANES = 4
) (
  input  logic                                  clk,
  input  vmem_bus_pkg::addr_t                   base,
  input  vmem_bus_pkg::addr_t                   stride,      // In elements
  input  vmem_op_pkg::op_t                      op,
  input  logic [NUM_LANES-1:0]                  vmask,
  input  vmem_bus_pkg::word_t [NUM_LANES-1:0]   vindex,      // Byte offsets
  input  vmem_bus_pkg::word_t [NUM_LANES-1:0]   vwritedata,
  vmem_elem_if.gen                              elem
);

  vmem_bus_pkg::addr_t                 step;       // Byte step per element
  vmem_bus_pkg::addr_t                 base_q;
  vmem_bus_pkg::addr_t                 step_q;
  vmem_bus_pkg::addr_t                 offset_q;   // elem * step, kept by addition
  logic                                is_index_q;
  logic [NUM_LANES-1:0]                mask_q;
  vmem_bus_pkg::word_t [NUM_LANES-1:0] vindex_q;
  vmem_bus_pkg::word_t [NUM_LANES-1:0] wdata_q;

  // Element bytes scale both unit and strided steps
  always_comb
  begin
    case (vmem_op_pkg::op_pattern(op))
      vmem_op_pkg::PAT_UNIT:
        step = vmem_bus_pkg::addr_t'(1) << vmem_op_pkg::size_shift(vmem_op_pkg::op_size(op));
      vmem_op_pkg::PAT_STRIDE:
        step = stride << vmem_op_pkg::size_shift(vmem_op_pkg::op_size(op));
      default:
        step = '0;  // Indexed uses vindex instead
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (elem.capture)
    begin
      base_q     <= base;
      step_q     <= step;
      offset_q   <= '0;
      is_index_q <= (vmem_op_pkg::op_pattern(op) == vmem_op_pkg::PAT_INDEX);
      mask_q     <= vmask;
      vindex_q   <= vindex;
      wdata_q    <= vwritedata;
    end
    else if (elem.advance)
      offset_q <= offset_q + step_q;  // Tracks elem, masked skips included
  end

  assign elem.mask_bit = mask_q[elem.elem];
  assign elem.wdata    = wdata_q[elem.elem];

  // Only elem changes during an element, so addr holds under wait
  assign elem.addr = is_index_q ? base_q + vindex_q[elem.elem]
                                : base_q + offset_q;

endmodule

// File: src/vmem_store_align.sv
/*
 * Store data alignment
 * Puts a byte, halfword or word at its big-endian spot in the word,
 * then moves data and byte enables to the addressed word of the line
 */

`timescale 1ns/100ps

module vmem_store_align #(
  parameter int LINE_WIDTH = 128
) (
  input  vmem_bus_pkg::addr_t    addr,
  input  vmem_bus_pkg::word_t    wdata,           // Element in low bits
  input  logic [1:0]             size,
  output logic [LINE_WIDTH-1:0]   dmem_writedata,
  output logic [LINE_WIDTH/8-1:0] dmem_byteen
);

  localparam int WSEL_WIDTH = vmem_bus_pkg::wsel_width(LINE_WIDTH);
  localparam int EN_WIDTH   = LINE_WIDTH / 8;

  vmem_bus_pkg::word_t   word_data;
  logic [3:0]            word_en;    // Bit 3 is byte 0, bits 31:24
  logic [WSEL_WIDTH-1:0] wsel;

  assign wsel = addr[vmem_bus_pkg::BYTE_SEL_WIDTH +: WSEL_WIDTH];

  always_comb
  begin
    case (size)
      vmem_op_pkg::SIZE_BYTE:
      begin
        word_data = {wdata[7:0], 24'h0} >> {addr[1:0], 3'b000};
        word_en   = 4'b1000 >> addr[1:0];
      end
      vmem_op_pkg::SIZE_HALF:
      begin
        word_data = {wdata[15:0], 16'h0} >> {addr[1], 4'b0000};  // addr[0] ignored
        word_en   = addr[1] ? 4'b0011 : 4'b1100;
      end
      default:
      begin
        word_data = wdata;  // Whole word
        word_en   = 4'b1111;
      end
    endcase
  end

  // Word 0 of the line sits in the low bits
  assign dmem_writedata = LINE_WIDTH'(word_data) << (wsel * vmem_bus_pkg::WORD_WIDTH);
  assign dmem_byteen    = EN_WIDTH'(word_en) << (wsel * 4);

endmodule

// File: src/vmem_load_align.sv
/*
 * Load data alignment and result write
 * Picks the word from the line, pulls out the element, extends it
 * and writes it to its result lane with a one-cycle enable
 */

`timescale 1ns/100ps

module vmem_load_align #(
  parameter int NUM_LANES  = 4,
  parameter int LINE_WIDTH = 128
) (
  input  logic                                                clk,
  input  logic                                                resetn,
  input  logic                                                load_take,
  input  logic [vmem_bus_pkg::lane_idx_width(NUM_LANES)-1:0] load_elem,
  input  vmem_bus_pkg::addr_t                                 addr,
  input  vmem_op_pkg::op_t                                    op,
  input  logic [LINE_WIDTH-1:0]                               dmem_readdata,
  output vmem_bus_pkg::word_t [NUM_LANES-1:0]                 voutput,
  output logic [NUM_LANES-1:0]                                voutput_we
);

  localparam int WSEL_WIDTH = vmem_bus_pkg::wsel_width(LINE_WIDTH);

  logic [WSEL_WIDTH-1:0] wsel;
  vmem_bus_pkg::word_t   rword;
  vmem_bus_pkg::word_t   byte_sh;   // Addressed byte moved to 31:24
  vmem_bus_pkg::word_t   half_sh;   // Addressed halfword moved to 31:16
  vmem_bus_pkg::word_t   result;
  logic                  sext;

  assign wsel    = addr[vmem_bus_pkg::BYTE_SEL_WIDTH +: WSEL_WIDTH];
  assign rword   = dmem_readdata[wsel * vmem_bus_pkg::WORD_WIDTH +: vmem_bus_pkg::WORD_WIDTH];
  assign byte_sh = rword << {addr[1:0], 3'b000};
  assign half_sh = rword << {addr[1], 4'b0000};
  assign sext    = vmem_op_pkg::op_signed(op);

  always_comb
  begin
    case (vmem_op_pkg::op_size(op))
      vmem_op_pkg::SIZE_BYTE:
        result = {{24{sext & byte_sh[31]}}, byte_sh[31:24]};
      vmem_op_pkg::SIZE_HALF:
        result = {{16{sext & half_sh[31]}}, half_sh[31:16]};
      default:
        result = rword;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      voutput    <= '0;
      voutput_we <= '0;
    end
    else
    begin
      voutput_we <= '0;  // Single-cycle pulse
      if (load_take)
      begin
        voutput[load_elem]    <= result;  // Lane keeps value afterwards
        voutput_we[load_elem] <= 1'b1;
      end
    end
  end

  // One element per request, so at most one lane written at a time
  a_we_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0(voutput_we));

endmodule

// File: src/vmem_unit.sv
/*
 * Vector memory unit
 * Unit, strided and indexed loads and stores, one element per
 * memory request, over a line-wide cache port with wait
 */

`timescale 1ns/100ps

module vmem_unit #(
  parameter int NUM_LANES  = 4,
  parameter int LINE_WIDTH = vmem_bus_pkg::LINE_WIDTH_DEFAULT
) (
  input  logic                                clk,
  input  logic                                resetn,
  // Instruction
  input  logic                                start,
  input  vmem_op_pkg::op_t                    op,
  input  vmem_bus_pkg::addr_t                 base,
  input  vmem_bus_pkg::addr_t                 stride,
  input  logic [NUM_LANES-1:0]                vmask,
  input  vmem_bus_pkg::word_t [NUM_LANES-1:0] vindex,
  input  vmem_bus_pkg::word_t [NUM_LANES-1:0] vwritedata,
  output logic                                busy,
  // Results
  output vmem_bus_pkg::word_t [NUM_LANES-1:0] voutput,
  output logic [NUM_LANES-1:0]                voutput_we,
  output logic                                done,
  // Memory port
  output logic                                dmem_en,
  output logic                                dmem_we,
  output vmem_bus_pkg::addr_t                 dmem_address,
  output logic [LINE_WIDTH/8-1:0]             dmem_byteen,
  output logic [LINE_WIDTH-1:0]               dmem_writedata,
  input  logic [LINE_WIDTH-1:0]               dmem_readdata,
  input  logic                                dmem_wait
);

  logic                                                load_take;
  logic [vmem_bus_pkg::lane_idx_width(NUM_LANES)-1:0] load_elem;

  vmem_elem_if #(.NUM_LANES(NUM_LANES)) elem_bus ();

  assign dmem_address = elem_bus.addr;  // Element address goes straight out

  vmem_ctrl #(.NUM_LANES(NUM_LANES)) u_ctrl (
    .clk       (clk),
    .resetn    (resetn),
    .start     (start),
    .op        (op),
    .busy      (busy),
    .done      (done),
    .elem      (elem_bus.ctrl),
    .dmem_en   (dmem_en),
    .dmem_we   (dmem_we),
    .dmem_wait (dmem_wait),
    .load_take (load_take),
    .load_elem (load_elem)
  );

  vmem_addr_gen #(.NUM_LANES(NUM_LANES)) u_addr_gen (
    .clk        (clk),
    .base       (base),
    .stride     (stride),
    .op         (op),
    .vmask      (vmask),
    .vindex     (vindex),
    .vwritedata (vwritedata),
    .elem       (elem_bus.gen)
  );

  vmem_store_align #(.LINE_WIDTH(LINE_WIDTH)) u_store_align (
    .addr           (elem_bus.addr),
    .wdata          (elem_bus.wdata),
    .size           (vmem_op_pkg::op_size(elem_bus.op)),
    .dmem_writedata (dmem_writedata),
    .dmem_byteen    (dmem_byteen)
  );

  vmem_load_align #(.NUM_LANES(NUM_LANES), .LINE_WIDTH(LINE_WIDTH)) u_load_align (
    .clk           (clk),
    .resetn        (resetn),
    .load_take     (load_take),
    .load_elem     (load_elem),
    .addr          (elem_bus.addr),
    .op            (elem_bus.op),   // Latched copy, valid for the whole op
    .dmem_readdata (dmem_readdata),
    .voutput       (voutput),
    .voutput_we    (voutput_we)
  );

endmodule

// File: testbench/vmem_unit_tb.sv
/*
 * Testbench for the vector memory unit
 * Line-wide memory model with random wait, byte-level reference
 * model and a compare process on the result lanes
 */

`timescale 1ns/100ps

module vmem_unit_tb;

  localparam int NUM_LANES      = 4;
  localparam int LINE_WIDTH     = 128;
  localparam int MEM_BYTES      = 1024;  // 64 lines, address bits 9:0
  localparam int NUM_TESTS      = 14;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * NUM_LANES * 12 + 100;

  typedef vmem_bus_pkg::word_t [NUM_LANES-1:0] lanes_t;

  logic                    clk, resetn, start, busy, done;
  vmem_op_pkg::op_t        op;
  vmem_bus_pkg::addr_t     base, stride, dmem_address;
  logic [NUM_LANES-1:0]    vmask, voutput_we;
  lanes_t                  vindex, vwritedata, voutput;
  logic                    dmem_en, dmem_we, dmem_wait;
  logic [LINE_WIDTH/8-1:0] dmem_byteen;
  logic [LINE_WIDTH-1:0]   dmem_writedata, dmem_readdata;

  logic [LINE_WIDTH-1:0] mem [MEM_BYTES/16];  // Memory seen by the DUT
  logic [7:0]            ref_mem [MEM_BYTES]; // Expected memory bytes
  vmem_bus_pkg::addr_t   exp_addr_q[$];       // Expected requests, in issue order
  lanes_t                exp_val;
  logic [NUM_LANES-1:0]  exp_we, seen_we;
  logic                  cur_store, wait_on;
  int                    done_count, value_errors, protocol_errors, cycle_count;

  vmem_unit #(.NUM_LANES(NUM_LANES), .LINE_WIDTH(LINE_WIDTH)) u_vmem_unit (
    .clk (clk), .resetn (resetn), .start (start), .op (op), .base (base),
    .stride (stride), .vmask (vmask), .vindex (vindex), .vwritedata (vwritedata),
    .busy (busy), .voutput (voutput), .voutput_we (voutput_we), .done (done),
    .dmem_en (dmem_en), .dmem_we (dmem_we), .dmem_address (dmem_address),
    .dmem_byteen (dmem_byteen), .dmem_writedata (dmem_writedata),
    .dmem_readdata (dmem_readdata), .dmem_wait (dmem_wait)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [7:0] fill_byte(int a);
    return 8'((a * 37) ^ (a >> 5));  // Upper bits folded in
  endfunction

  // Bit offset of a byte in its line with byte 0 of a word at 31:24
  function automatic int bit_pos(int a);
    return ((a / 4) % 4) * 32 + (3 - a % 4) * 8;
  endfunction

  function automatic vmem_op_pkg::op_t make_op(logic [1:0] pat, logic [1:0] size,
                                               logic sgn, logic st);
    vmem_op_pkg::op_t o;
    o = '0;
    o[vmem_op_pkg::OP_PAT_LSB +: 2]    = pat;
    o[vmem_op_pkg::OP_SIZE_LSB +: 2]   = size;
    o[vmem_op_pkg::OP_SIGNED_BIT]      = sgn;
    o[vmem_op_pkg::OP_STORE_BIT]       = st;
    return o;
  endfunction

  function automatic vmem_bus_pkg::addr_t size_bytes(logic [1:0] size);
    case (size)
      vmem_op_pkg::SIZE_BYTE: return 32'd1;
      vmem_op_pkg::SIZE_HALF: return 32'd2;
      default:                return 32'd4;
    endcase
  endfunction

  function automatic vmem_bus_pkg::addr_t elem_addr(logic [1:0] pat, logic [1:0] size,
      vmem_bus_pkg::addr_t b, vmem_bus_pkg::addr_t s, lanes_t idx, int lane);
    vmem_bus_pkg::addr_t n;
    n = vmem_bus_pkg::addr_t'(lane);
    case (pat)
      vmem_op_pkg::PAT_UNIT:   return b + n * size_bytes(size);
      vmem_op_pkg::PAT_STRIDE: return b + n * s * size_bytes(size);
      default:                 return b + idx[lane];
    endcase
  endfunction

  // Expected load result from the reference bytes
  function automatic vmem_bus_pkg::word_t load_ref(vmem_bus_pkg::addr_t a, logic [1:0] size,
                                                   logic sgn);
    int b;
    b = int'(a[9:0]);
    case (size)
      vmem_op_pkg::SIZE_BYTE:
        return {{24{sgn & ref_mem[b][7]}}, ref_mem[b]};
      vmem_op_pkg::SIZE_HALF:
      begin
        b = b & ~1;  // High byte first
        return {{16{sgn & ref_mem[b][7]}}, ref_mem[b], ref_mem[b+1]};
      end
      default:
      begin
        b = b & ~3;
        return {ref_mem[b], ref_mem[b+1], ref_mem[b+2], ref_mem[b+3]};
      end
    endcase
  endfunction

  function automatic void ref_store(vmem_bus_pkg::addr_t a, logic [1:0] size,
                                    vmem_bus_pkg::word_t d);
    int b;
    b = int'(a[9:0]);
    if (size == vmem_op_pkg::SIZE_BYTE)
      ref_mem[b] = d[7:0];
    else if (size == vmem_op_pkg::SIZE_HALF)
    begin
      b = b & ~1;
      ref_mem[b]   = d[15:8];
      ref_mem[b+1] = d[7:0];
    end
    else
    begin
      b = b & ~3;
      for (int i = 0; i < 4; i++)
        ref_mem[b+i] = d[31-8*i -: 8];
    end
  endfunction

  function automatic lanes_t rand_lanes();
    lanes_t r;
    for (int l = 0; l < NUM_LANES; l++)
      r[l] = $urandom;
    return r;
  endfunction

  // One request per edge and read data one cycle later
  initial
  begin : mem_model
    logic                  acc, wr, hold, hold_we;
    logic [5:0]            line;
    vmem_bus_pkg::addr_t   hold_addr, exp;
    logic [LINE_WIDTH-1:0] wr_data;
    logic [LINE_WIDTH/8-1:0] wr_en;
    for (int a = 0; a < MEM_BYTES; a++)
      mem[a / 16][bit_pos(a) +: 8] = fill_byte(a);
    dmem_readdata = '0;
    dmem_wait     = 1'b0;
    hold          = 1'b0;
    hold_we       = 1'b0;
    hold_addr     = '0;
    forever
    begin
      @(posedge clk);
      acc  = resetn && dmem_en && !dmem_wait;
      wr   = acc && dmem_we;
      line = dmem_address[9:4];
      if (hold)
        assert (dmem_en && dmem_address == hold_addr && dmem_we == hold_we)
        else
        begin
          protocol_errors++;
          $display("request changed while wait was high at %0t ns", $time);
        end
      hold      = resetn && dmem_en && dmem_wait;
      hold_addr = dmem_address;
      hold_we   = dmem_we;
      assert (!acc || exp_addr_q.size() > 0)
      else
      begin
        protocol_errors++;
        $display("request issued with no element pending at %0t ns", $time);
      end
      if (acc && exp_addr_q.size() > 0)
      begin
        exp = exp_addr_q.pop_front();
        assert (dmem_address == exp && dmem_we == cur_store)
        else
        begin
          value_errors++;
          $display("error: %0t ns: request at %h we %b, expected %h we %b",
                   $time, dmem_address, dmem_we, exp, cur_store);
        end
      end
      wr_data = dmem_writedata;
      wr_en   = dmem_byteen;
      #1;
      if (wr)
      begin
        for (int i = 0; i < LINE_WIDTH / 8; i++)
          if (wr_en[i])
            mem[line][i*8 +: 8] = wr_data[i*8 +: 8];  // Enabled bytes only
      end
      else if (acc)
        dmem_readdata = mem[line];
      dmem_wait = wait_on && ($urandom_range(3) == 0);  // Wait about one cycle in four
    end
  end

  // Compare process on result writes and done pulses
  always @(posedge clk)
  begin
    if (resetn)
    begin
      if (done)
        done_count++;
      for (int l = 0; l < NUM_LANES; l++)
        if (voutput_we[l])
        begin
          assert (exp_we[l] && !seen_we[l])
          else
          begin
            protocol_errors++;
            $display("unexpected result write on lane %0d at %0t ns", l, $time);
          end
          assert (voutput[l] == exp_val[l])
          else
          begin
            value_errors++;
            $display("error: %0t ns: lane %0d got %h, expected %h",
                     $time, l, voutput[l], exp_val[l]);
          end
          seen_we[l] = 1'b1;
        end
    end
  end

  // One instruction, driven 1 ns after an edge, ends 1 ns after an edge
  task automatic run_op(input logic [1:0] pat, input logic [1:0] size, input logic sgn,
                        input logic st, input vmem_bus_pkg::addr_t b,
                        input vmem_bus_pkg::addr_t s, input logic [NUM_LANES-1:0] m,
                        input lanes_t idx, input lanes_t wd, input logic wt);
    vmem_bus_pkg::addr_t a;
    exp_addr_q.delete();
    exp_we     = '0;
    seen_we    = '0;
    done_count = 0;
    cur_store  = st;
    wait_on    = wt;
    for (int l = 0; l < NUM_LANES; l++)
      if (m[l])
      begin
        a = elem_addr(pat, size, b, s, idx, l);
        exp_addr_q.push_back(a);
        if (st)
          ref_store(a, size, wd[l]);  // Lane order matches issue order
        else
        begin
          exp_val[l] = load_ref(a, size, sgn);
          exp_we[l]  = 1'b1;
        end
      end
    start      = 1'b1;
    op         = make_op(pat, size, sgn, st);
    base       = b;
    stride     = s;
    vmask      = m;
    vindex     = idx;
    vwritedata = wd;
    @(posedge clk);
    #1;
    start      = 1'b0;
    op         = vmem_op_pkg::op_t'($urandom);  // Operands only valid with start
    base       = $urandom;
    stride     = $urandom;
    vmask      = NUM_LANES'($urandom);
    vindex     = rand_lanes();
    vwritedata = rand_lanes();
    assert (busy)
    else
    begin
      protocol_errors++;
      $display("busy did not rise after start at %0t ns", $time);
    end
    @(posedge clk);
    while (!done)
      @(posedge clk);
    #1;
    @(posedge clk);
    assert (!busy && !done && done_count == 1)
    else
    begin
      protocol_errors++;
      $display("instruction did not end with one done pulse and busy low at %0t ns", $time);
    end
    assert (exp_addr_q.size() == 0)
    else
    begin
      protocol_errors++;
      $display("%0d expected requests never issued", exp_addr_q.size());
    end
    assert (seen_we == exp_we)
    else
    begin
      protocol_errors++;
      $display("result lanes written %b, expected %b", seen_we, exp_we);
    end
    #1;
  endtask

  initial
  begin : main
    lanes_t wd, idx, saved;
    void'($urandom(50));
    value_errors    = 0;
    protocol_errors = 0;
    done_count      = 0;
    cur_store       = 1'b0;
    wait_on         = 1'b0;
    exp_val         = '0;
    exp_we          = '0;
    seen_we         = '0;
    resetn          = 1'b0;
    start           = 1'b0;
    op              = '0;
    base            = '0;
    stride          = '0;
    vmask           = '0;
    vindex          = '0;
    vwritedata      = '0;
    for (int a = 0; a < MEM_BYTES; a++)
      ref_mem[a] = fill_byte(a);
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b1;

    // Known words with mixed sign bits for the narrow loads
    wd = {32'h4c5d6e7f, 32'h08192a3b, 32'hc4d5e6f7, 32'h8091a2b3};
    run_op(vmem_op_pkg::PAT_UNIT, vmem_op_pkg::SIZE_WORD, 0, 1, 32'h100, 0, 4'hf, '0, wd, 0);
    run_op(vmem_op_pkg::PAT_UNIT, vmem_op_pkg::SIZE_WORD, 0, 0, 32'h100, 0, 4'hf, '0, '0, 0);
    run_op(vmem_op_pkg::PAT_STRIDE, vmem_op_pkg::SIZE_BYTE, 1, 0, 32'h100, 3, 4'hf, '0, '0, 0);
    run_op(vmem_op_pkg::PAT_STRIDE, vmem_op_pkg::SIZE_BYTE, 0, 0, 32'h100, 3, 4'hf, '0, '0, 0);
    run_op(vmem_op_pkg::PAT_STRIDE, vmem_op_pkg::SIZE_HALF, 1, 0, 32'h100, 3, 4'hf, '0, '0, 0);
    run_op(vmem_op_pkg::PAT_STRIDE, vmem_op_pkg::SIZE_HALF, 0, 0, 32'h100, 3, 4'hf, '0, '0, 0);

    // Indexed stores, then a load back over a partly overwritten word
    idx = {32'h10, 32'h24, 32'h08, 32'h3c};
    run_op(vmem_op_pkg::PAT_INDEX, vmem_op_pkg::SIZE_WORD, 0, 1, 32'h200, 0, 4'hf, idx,
           rand_lanes(), 0);
    run_op(vmem_op_pkg::PAT_INDEX, vmem_op_pkg::SIZE_BYTE, 0, 1, 32'h205, 0, 4'hf,
           {32'h1b, 32'h11, 32'h06, 32'h00}, rand_lanes(), 0);
    run_op(vmem_op_pkg::PAT_INDEX, vmem_op_pkg::SIZE_WORD, 0, 0, 32'h200, 0, 4'hf, idx, '0, 0);
    saved = voutput;

    // Masked lanes skip memory and results
    run_op(vmem_op_pkg::PAT_UNIT, vmem_op_pkg::SIZE_WORD, 0, 1, 32'h300, 0, 4'b0101, '0,
           rand_lanes(), 0);
    run_op(vmem_op_pkg::PAT_STRIDE, vmem_op_pkg::SIZE_HALF, 1, 0, 32'h300, 2, 4'b0110, '0,
           '0, 0);

    // Same indexed load under back-pressure
    run_op(vmem_op_pkg::PAT_INDEX, vmem_op_pkg::SIZE_WORD, 0, 0, 32'h200, 0, 4'hf, idx, '0, 1);
    assert (voutput == saved)
    else
    begin
      value_errors++;
      $display("error: %0t ns: results under wait %h differ from %h", $time, voutput, saved);
    end
    run_op(vmem_op_pkg::PAT_INDEX, vmem_op_pkg::SIZE_HALF, 0, 1, 32'h280, 0, 4'b1011,
           {32'h02, 32'h1a, 32'h06, 32'h0e}, rand_lanes(), 1);
    run_op(vmem_op_pkg::PAT_STRIDE, vmem_op_pkg::SIZE_BYTE, 1, 0, 32'h282, 1, 4'hf, '0, '0, 1);

    for (int a = 0; a < MEM_BYTES; a++)
      assert (mem[a / 16][bit_pos(a) +: 8] == ref_mem[a])
      else
      begin
        value_errors++;
        $display("error: %0t ns: memory byte %h is %h, expected %h",
                 $time, a, mem[a / 16][bit_pos(a) +: 8], ref_mem[a]);
      end

    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: build.f
src/vmem_bus_pkg.sv
src/vmem_op_pkg.sv
src/vmem_elem_if.sv
src/vmem_ctrl.sv
src/vmem_addr_gen.sv
src/vmem_store_align.sv
src/vmem_load_align.sv
src/vmem_unit.sv
testbench/vmem_unit_tb.sv

// File: Makefile
# Verilator build and run for the vector memory unit
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= vmem_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
